// ==== hdl/cpu8_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width and depth macros for the 8-bit teaching CPU and its display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU8_CFG_SVH
`define CPU8_CFG_SVH

// Datapath
`define CPU_WORD_W       8   // Data and address width
`define CPU_OPCODE_W     7

// Data memory
`define CPU_DMEM_DEPTH   32
`define CPU_DMEM_ADDR_W  5   // Low address bits used as index

// Board front end
`define CPU_SEG_W        7   // Segments a..g per digit
`define CPU_LED_W        4

`endif

// ==== hdl/cpu8_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction, control word, flag, ALU and display types
// Opcode constants of the kept instruction set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "cpu8_cfg.svh"

package cpu8_pkg;

    typedef logic [`CPU_WORD_W-1:0]   word_t;
    typedef logic [`CPU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CPU_SEG_W-1:0]    seg_t;    // a in MSB, g in LSB, low lights

    typedef struct packed {
        opcode_t opcode;
        word_t   operand;   // Literal, jump target or direct address
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_XOR, ALU_SHL, ALU_SHR
    } alu_op_t;

    typedef enum logic [1:0] {SEL_A_REG_A, SEL_A_ONE, SEL_A_ZERO, SEL_A_REG_B} sel_a_t;
    typedef enum logic [1:0] {SEL_B_REG_B, SEL_B_MEM, SEL_B_LIT, SEL_B_ZERO} sel_b_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic    jump;
        logic    mem_wr;
        logic    addr_from_b;
        logic    load_a;
        logic    load_b;
        sel_a_t  sel_a;
        sel_b_t  sel_b;
        alu_op_t alu_op;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        jump: 1'b0, mem_wr: 1'b0, addr_from_b: 1'b0, load_a: 1'b0, load_b: 1'b0,
        sel_a: SEL_A_REG_A, sel_b: SEL_B_REG_B, alu_op: ALU_ADD
    };

    typedef enum logic [1:0] {VIEW_PC, VIEW_REG_A, VIEW_REG_B, VIEW_ALU} view_t;

    // Kept opcodes
    localparam opcode_t OP_MOV_A_B   = 7'h00;
    localparam opcode_t OP_MOV_B_A   = 7'h01;
    localparam opcode_t OP_MOV_A_LIT = 7'h02;
    localparam opcode_t OP_MOV_B_LIT = 7'h03;
    localparam opcode_t OP_ADD_A_B   = 7'h04;
    localparam opcode_t OP_ADD_A_LIT = 7'h06;
    localparam opcode_t OP_SUB_A_B   = 7'h08;
    localparam opcode_t OP_SUB_A_LIT = 7'h0A;
    localparam opcode_t OP_AND_A_B   = 7'h0C;
    localparam opcode_t OP_OR_A_B    = 7'h10;
    localparam opcode_t OP_NOT_A     = 7'h14;
    localparam opcode_t OP_XOR_A_B   = 7'h18;
    localparam opcode_t OP_SHL_A     = 7'h1C;
    localparam opcode_t OP_SHR_A     = 7'h20;
    localparam opcode_t OP_MOV_A_MEM = 7'h25;   // A = mem[lit]
    localparam opcode_t OP_MOV_MEM_A = 7'h27;   // mem[lit] = A
    localparam opcode_t OP_JMP       = 7'h53;
    localparam opcode_t OP_JEQ       = 7'h54;
    localparam opcode_t OP_JNE       = 7'h55;
    localparam opcode_t OP_JCS       = 7'h5A;

endpackage

// ==== hdl/program_rom.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed program ROM, countdown loop then carry test and halt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module program_rom
    import cpu8_pkg::*;
(
    input  word_t  i_pc,
    output instr_t o_instr
);

    always_comb begin
        case (i_pc)
            // Count A down from B, mirror into mem[7]
            8'd0:    o_instr = '{OP_MOV_B_LIT, word_t'(5)};
            8'd1:    o_instr = '{OP_MOV_A_B,   word_t'(0)};
            8'd2:    o_instr = '{OP_SUB_A_LIT, word_t'(1)};     // Loop head
            8'd3:    o_instr = '{OP_MOV_MEM_A, word_t'(7)};
            8'd4:    o_instr = '{OP_JNE,       word_t'(2)};
            // 200 + 100 overflows 8 bits and sets c
            8'd5:    o_instr = '{OP_MOV_A_LIT, word_t'(200)};
            8'd6:    o_instr = '{OP_ADD_A_LIT, word_t'(100)};
            8'd7:    o_instr = '{OP_JCS,       word_t'(10)};
            8'd8:    o_instr = '{OP_MOV_A_LIT, word_t'(255)};   // Skipped if carry
            8'd9:    o_instr = '{OP_MOV_B_LIT, word_t'(9)};
            8'd10:   o_instr = '{OP_MOV_B_A,   word_t'(0)};
            8'd11:   o_instr = '{OP_MOV_A_MEM, word_t'(7)};
            8'd12:   o_instr = '{OP_NOT_A,     word_t'(0)};
            8'd13:   o_instr = '{OP_JMP,       word_t'(13)};    // Halt in place
            default: o_instr = '{OP_MOV_A_B,   word_t'(0)};
        endcase
    end

endmodule

// ==== hdl/instr_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder, opcode and latched flags to control word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decoder
    import cpu8_pkg::*;
(
    input  opcode_t i_opcode,
    input  flags_t  i_flags,
    output ctrl_t   o_ctrl
);

    // ALU type instruction writing A or B
    function automatic ctrl_t alu_ctrl(
        input logic    load_a,
        input logic    load_b,
        input sel_a_t  sel_a,
        input sel_b_t  sel_b,
        input alu_op_t op
    );
        ctrl_t c;
        c        = CTRL_NOP;
        c.load_a = load_a;
        c.load_b = load_b;
        c.sel_a  = sel_a;
        c.sel_b  = sel_b;
        c.alu_op = op;
        return c;
    endfunction

    // Jump word, everything else idle
    function automatic ctrl_t jump_ctrl(input logic taken);
        ctrl_t c;
        c      = CTRL_NOP;
        c.jump = taken;
        return c;
    endfunction

    always_comb begin
        o_ctrl = CTRL_NOP;  // Unknown opcodes do nothing
        case (i_opcode)
            OP_MOV_A_B:   o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_ZERO,  SEL_B_REG_B, ALU_ADD);
            OP_MOV_B_A:   o_ctrl = alu_ctrl(1'b0, 1'b1, SEL_A_REG_A, SEL_B_ZERO,  ALU_ADD);
            OP_MOV_A_LIT: o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_ZERO,  SEL_B_LIT,   ALU_ADD);
            OP_MOV_B_LIT: o_ctrl = alu_ctrl(1'b0, 1'b1, SEL_A_ZERO,  SEL_B_LIT,   ALU_ADD);
            OP_ADD_A_B:   o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_ADD);
            OP_ADD_A_LIT: o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_LIT,   ALU_ADD);
            OP_SUB_A_B:   o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_SUB);
            OP_SUB_A_LIT: o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_LIT,   ALU_SUB);
            OP_AND_A_B:   o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_AND);
            OP_OR_A_B:    o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_OR);
            OP_NOT_A:     o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_NOT);
            OP_XOR_A_B:   o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_XOR);
            OP_SHL_A:     o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_SHL);
            OP_SHR_A:     o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_REG_A, SEL_B_REG_B, ALU_SHR);
            OP_MOV_A_MEM: o_ctrl = alu_ctrl(1'b1, 1'b0, SEL_A_ZERO,  SEL_B_MEM,   ALU_ADD);
            OP_MOV_MEM_A: begin
                // Store passes A through the adder
                o_ctrl        = alu_ctrl(1'b0, 1'b0, SEL_A_REG_A, SEL_B_ZERO, ALU_ADD);
                o_ctrl.mem_wr = 1'b1;
            end
            OP_JMP:       o_ctrl = jump_ctrl(1'b1);
            OP_JEQ:       o_ctrl = jump_ctrl(i_flags.z);
            OP_JNE:       o_ctrl = jump_ctrl(~i_flags.z);
            OP_JCS:       o_ctrl = jump_ctrl(i_flags.c);
            default:      o_ctrl = CTRL_NOP;
        endcase
    end

endmodule

// ==== hdl/cpu_alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight-operation ALU with z, n, c and v flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_alu
    import cpu8_pkg::*;
(
    input  word_t   i_a,
    input  word_t   i_b,
    input  alu_op_t i_op,
    output word_t   o_result,
    output flags_t  o_flags
);

    logic [`CPU_WORD_W:0] wide;     // One extra bit for carry out

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_NOT: o_result = ~i_a;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SHL: o_result = i_a << 1;
            ALU_SHR: o_result = i_a >> 1;
            default: o_result = '0;
        endcase
    end

    // Carry taken from the add path unless subtracting
    always_comb begin
        if (i_op == ALU_SUB) begin
            wide = {1'b0, i_a} - {1'b0, i_b};   // Top bit is the borrow
        end else begin
            wide = {1'b0, i_a} + {1'b0, i_b};
        end
    end

    assign o_flags.z = (o_result == '0);
    assign o_flags.n = o_result[`CPU_WORD_W-1];
    assign o_flags.c = wide[`CPU_WORD_W];
    // Same-sign operands giving a result of the other sign
    assign o_flags.v = (i_a[`CPU_WORD_W-1] == i_b[`CPU_WORD_W-1]) &&
                       (o_result[`CPU_WORD_W-1] != i_a[`CPU_WORD_W-1]);

endmodule

// ==== hdl/cpu_datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU state with PC, registers A and B, status register, data memory
// Operand and address multiplexers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu8_cfg.svh"

module cpu_datapath
    import cpu8_pkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    input  logic    i_advance,      // One instruction per cycle while high
    input  instr_t  i_instr,
    input  ctrl_t   i_ctrl,
    input  word_t   i_alu_result,
    input  flags_t  i_alu_flags,
    output word_t   o_pc,
    output opcode_t o_opcode,
    output flags_t  o_flags,
    output word_t   o_alu_a,
    output word_t   o_alu_b,
    output alu_op_t o_alu_op,
    output word_t   o_reg_a,
    output word_t   o_reg_b
);

    word_t                       dmem [`CPU_DMEM_DEPTH];
    word_t                       addr;
    logic [`CPU_DMEM_ADDR_W-1:0] dmem_idx;
    word_t                       dmem_rd;

    assign o_opcode = i_instr.opcode;
    assign o_alu_op = i_ctrl.alu_op;

    // Direct address from the instruction or indirect through B
    assign addr     = i_ctrl.addr_from_b ? o_reg_b : i_instr.operand;
    assign dmem_idx = addr[`CPU_DMEM_ADDR_W-1:0];
    assign dmem_rd  = dmem[dmem_idx];   // Asynchronous read

    always_comb begin
        case (i_ctrl.sel_a)
            SEL_A_REG_A: o_alu_a = o_reg_a;
            SEL_A_ONE:   o_alu_a = word_t'(1);
            SEL_A_ZERO:  o_alu_a = '0;
            SEL_A_REG_B: o_alu_a = o_reg_b;
            default:     o_alu_a = o_reg_a;
        endcase
    end

    always_comb begin
        case (i_ctrl.sel_b)
            SEL_B_REG_B: o_alu_b = o_reg_b;
            SEL_B_MEM:   o_alu_b = dmem_rd;
            SEL_B_LIT:   o_alu_b = i_instr.operand;
            SEL_B_ZERO:  o_alu_b = '0;
            default:     o_alu_b = o_reg_b;
        endcase
    end

    // Program counter
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            o_pc <= '0;
        end else if (i_advance) begin
            if (i_ctrl.jump) begin
                o_pc <= i_instr.operand;
            end else begin
                o_pc <= o_pc + 1'b1;
            end
        end
    end

    // A and B load on demand and the flags follow every instruction
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            o_reg_a <= '0;
            o_reg_b <= '0;
            o_flags <= '0;
        end else if (i_advance) begin
            if (i_ctrl.load_a) o_reg_a <= i_alu_result;
            if (i_ctrl.load_b) o_reg_b <= i_alu_result;
            o_flags <= i_alu_flags;
        end
    end

    // Data memory written from the ALU result
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_advance && i_ctrl.mem_wr) begin
            dmem[dmem_idx] <= i_alu_result;
        end
    end

endmodule

// ==== hdl/seg_display.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board display: view select, decimal split, seven-segment and LEDs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu8_cfg.svh"

module seg_display
    import cpu8_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  i_view_next,
    input  word_t                 i_pc,
    input  word_t                 i_reg_a,
    input  word_t                 i_reg_b,
    input  word_t                 i_alu,
    output logic [`CPU_LED_W-1:0] o_leds,
    output seg_t                  o_seg_tens,
    output seg_t                  o_seg_ones
);

    view_t      view;
    word_t      shown;
    logic [3:0] nibble;
    logic [3:0] ones;
    logic       tens;

    // Active-low pattern for one decimal digit, abcdefg
    function automatic seg_t digit_seg(input logic [3:0] d);
        case (d)
            4'd0:    return 7'b000_0001;
            4'd1:    return 7'b100_1111;
            4'd2:    return 7'b001_0010;
            4'd3:    return 7'b000_0110;
            4'd4:    return 7'b100_1100;
            4'd5:    return 7'b010_0100;
            4'd6:    return 7'b010_0000;
            4'd7:    return 7'b000_1111;
            4'd8:    return 7'b000_0000;
            4'd9:    return 7'b000_0100;
            default: return 7'b111_1111;    // Dark
        endcase
    endfunction

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            view <= VIEW_PC;
        end else if (i_view_next) begin
            view <= (view == VIEW_ALU) ? VIEW_PC : view_t'(view + 1'b1);
        end
    end

    always_comb begin
        case (view)
            VIEW_PC:    shown = i_pc;
            VIEW_REG_A: shown = i_reg_a;
            VIEW_REG_B: shown = i_reg_b;
            VIEW_ALU:   shown = i_alu;
            default:    shown = i_pc;
        endcase
    end

    // Only the low nibble is shown, so 00 to 15
    assign nibble = shown[3:0];
    assign tens   = (nibble >= 4'd10);
    assign ones   = tens ? nibble - 4'd10 : nibble;

    assign o_seg_tens = digit_seg({3'b000, tens});
    assign o_seg_ones = digit_seg(ones);
    assign o_leds     = i_pc[`CPU_LED_W-1:0];

endmodule

// ==== hdl/cpu8_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level: CPU core with run/step control and board display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu8_cfg.svh"

module cpu8_top
    import cpu8_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  i_run,        // Level, runs every cycle
    input  logic                  i_step,       // One-cycle strobe
    input  logic                  i_view_next,
    output logic [`CPU_LED_W-1:0] o_leds,
    output seg_t                  o_seg_tens,
    output seg_t                  o_seg_ones
);

    word_t   pc;
    word_t   reg_a;
    word_t   reg_b;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    instr_t  instr;
    opcode_t opcode;
    ctrl_t   ctrl;
    flags_t  flags;
    flags_t  alu_flags;
    alu_op_t alu_op;

    program_rom program_rom_i (
        .i_pc    (pc),
        .o_instr (instr)
    );

    instr_decoder instr_decoder_i (
        .i_opcode (opcode),
        .i_flags  (flags),
        .o_ctrl   (ctrl)
    );

    cpu_alu cpu_alu_i (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_op     (alu_op),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    cpu_datapath cpu_datapath_i (
        .CLK          (CLK),
        .rst          (rst),
        .i_advance    (i_run | i_step),     // Clock enable for the whole core
        .i_instr      (instr),
        .i_ctrl       (ctrl),
        .i_alu_result (alu_result),
        .i_alu_flags  (alu_flags),
        .o_pc         (pc),
        .o_opcode     (opcode),
        .o_flags      (flags),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_alu_op     (alu_op),
        .o_reg_a      (reg_a),
        .o_reg_b      (reg_b)
    );

    seg_display seg_display_i (
        .CLK         (CLK),
        .rst         (rst),
        .i_view_next (i_view_next),
        .i_pc        (pc),
        .i_reg_a     (reg_a),
        .i_reg_b     (reg_b),
        .i_alu       (alu_result),
        .o_leds      (o_leds),
        .o_seg_tens  (o_seg_tens),
        .o_seg_ones  (o_seg_ones)
    );

endmodule

// ==== test/cpu8_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the teaching CPU with clock, reset, program model,
// step, hold, loop and run-to-halt tests with display checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "cpu8_cfg.svh"

module cpu8_tb
    import cpu8_pkg::*;
;

    logic                  CLK;
    logic                  rst;
    logic                  i_run;
    logic                  i_step;
    logic                  i_view_next;
    logic [`CPU_LED_W-1:0] o_leds;
    seg_t                  o_seg_tens;
    seg_t                  o_seg_ones;

    int    errors;
    int    checks;
    int    tests;
    int    test_err_start;
    string test_name;

    // Program model state
    word_t m_pc;
    word_t m_a;
    word_t m_b;
    word_t m_mem7;      // The program only touches address 7
    logic  m_z;
    logic  m_c;
    // Current instruction evaluated from model state
    word_t e_res;
    word_t e_target;
    logic  e_c;
    logic  e_jump;
    logic  e_load_a;
    logic  e_load_b;
    logic  e_mem_wr;

    cpu8_top cpu8_top_i (
        .CLK         (CLK),
        .rst         (rst),
        .i_run       (i_run),
        .i_step      (i_step),
        .i_view_next (i_view_next),
        .o_leds      (o_leds),
        .o_seg_tens  (o_seg_tens),
        .o_seg_ones  (o_seg_ones)
    );

    always #5 CLK = ~CLK;

    // Active-low abcdefg with a in the MSB
    function automatic seg_t digit_segments(input int d);
        case (d)
            0:       return 7'b0000001;
            1:       return 7'b1001111;
            2:       return 7'b0010010;
            3:       return 7'b0000110;
            4:       return 7'b1001100;
            5:       return 7'b0100100;
            6:       return 7'b0100000;
            7:       return 7'b0001111;
            8:       return 7'b0000000;
            9:       return 7'b0000100;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s (%s): expected %0d, actual %0d", test_name, name, exp, act);
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s (%s): expected %b, actual %b", test_name, name, exp, act);
        end
    endtask

    // Low nibble as two decimal digits
    task automatic check_display(input string name, input word_t value);
        int nib;
        nib = value[3:0];
        check_seg({name, " tens"}, digit_segments(nib / 10), o_seg_tens);
        check_seg({name, " ones"}, digit_segments(nib % 10), o_seg_ones);
    endtask

    task automatic check_leds(input string name);
        check_word(name, word_t'(m_pc[3:0]), word_t'(o_leds));
    endtask

    // Evaluate the instruction at m_pc from the program listing
    task automatic model_decode();
        word_t x;
        word_t y;
        logic  sub;
        logic  inv;
        logic [8:0] wide;
        x        = m_a;         // Jumps and no-ops add A and B
        y        = m_b;
        sub      = 1'b0;
        inv      = 1'b0;
        e_jump   = 1'b0;
        e_load_a = 1'b0;
        e_load_b = 1'b0;
        e_mem_wr = 1'b0;
        e_target = m_pc;
        case (m_pc)
            8'd0: begin
                x        = 0;
                y        = 5;
                e_load_b = 1'b1;
            end
            8'd1: begin
                x        = 0;
                e_load_a = 1'b1;
            end
            8'd2: begin
                y        = 1;
                sub      = 1'b1;
                e_load_a = 1'b1;
            end
            8'd3: begin
                y        = 0;
                e_mem_wr = 1'b1;
            end
            8'd4: begin
                e_jump   = !m_z;
                e_target = 2;
            end
            8'd5: begin
                x        = 0;
                y        = 200;
                e_load_a = 1'b1;
            end
            8'd6: begin
                y        = 100;
                e_load_a = 1'b1;
            end
            8'd7: begin
                e_jump   = m_c;
                e_target = 10;
            end
            8'd8: begin
                x        = 0;
                y        = 255;
                e_load_a = 1'b1;
            end
            8'd9: begin
                x        = 0;
                y        = 9;
                e_load_b = 1'b1;
            end
            8'd10: begin
                y        = 0;
                e_load_b = 1'b1;
            end
            8'd11: begin
                x        = 0;
                y        = m_mem7;
                e_load_a = 1'b1;
            end
            8'd12: begin
                inv      = 1'b1;
                e_load_a = 1'b1;
            end
            8'd13: begin
                e_jump   = 1'b1;
                e_target = 13;
            end
            default: begin
                x        = 0;
                e_load_a = 1'b1;
            end
        endcase
        wide  = sub ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});
        e_res = inv ? ~x : wide[7:0];
        e_c   = wide[8];
    endtask

    task automatic model_advance();
        model_decode();
        if (e_load_a) m_a = e_res;
        if (e_load_b) m_b = e_res;
        if (e_mem_wr) m_mem7 = e_res;
        m_z  = (e_res == 0);
        m_c  = e_c;
        m_pc = e_jump ? e_target : m_pc + 1;
        model_decode();     // Refresh the ALU view for the new state
    endtask

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge CLK);
        end
        #1;
    endtask

    task automatic step_once();
        @(posedge CLK);
        #1 i_step = 1'b1;
        @(posedge CLK);
        #1 i_step = 1'b0;
        model_advance();
    endtask

    task automatic press_view();
        @(posedge CLK);
        #1 i_view_next = 1'b1;
        @(posedge CLK);
        #1 i_view_next = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_err_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_err_start);
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        check_word("leds", 0, word_t'(o_leds));
        check_display("pc view", 0);
        end_test();
    endtask

    task automatic test_single_step();
        word_t exp_pc [5] = '{1, 2, 3, 4, 2};
        start_test("single_step");
        for (int i = 0; i < 5; i++) begin
            step_once();
            check_word($sformatf("leds after step %0d", i + 1), exp_pc[i], word_t'(o_leds));
            check_leds("leds against model");
        end
        end_test();
    endtask

    task automatic test_hold();
        logic [`CPU_LED_W-1:0] leds0;
        seg_t                  tens0;
        seg_t                  ones0;
        start_test("hold");
        leds0 = o_leds;
        tens0 = o_seg_tens;
        ones0 = o_seg_ones;
        for (int i = 0; i < 20; i++) begin
            wait_cycles(1);
            check_word("leds held", word_t'(leds0), word_t'(o_leds));
            check_seg("tens held", tens0, o_seg_tens);
            check_seg("ones held", ones0, o_seg_ones);
        end
        end_test();
    endtask

    task automatic test_loop_memory();
        start_test("loop_memory");
        for (int i = 0; i < 12; i++) begin
            step_once();
            check_leds($sformatf("leds after advance %0d", i + 6));
        end
        check_word("pc after 17 advances", 5, word_t'(o_leds));
        press_view();
        check_display("a view", m_a);
        press_view();
        check_display("b view", m_b);
        press_view();
        check_display("alu view", e_res);
        press_view();
        check_display("pc view", m_pc);
        end_test();
    endtask

    task automatic test_run_to_halt();
        int reached;
        start_test("run_to_halt");
        reached = -1;
        @(posedge CLK);
        #1 i_run = 1'b1;
        // Run the full window and note when the PC first reaches 13
        for (int i = 0; i < 40; i++) begin
            @(posedge CLK);
            #1;
            model_advance();
            check_leds("leds while running");
            if (reached < 0 && o_leds == 4'd13) reached = i;
        end
        i_run = 1'b0;
        if (reached < 0) begin
            errors++;
            $display("%s: timed out after 40 cycles waiting for the PC to reach 13", test_name);
        end
        check_word("halt pc", 13, word_t'(o_leds));
        press_view();
        check_display("a view", m_a);
        press_view();
        check_display("b view", m_b);
        press_view();
        check_display("alu view", e_res);
        press_view();
        check_display("pc view wrap", m_pc);
        end_test();
    endtask

    initial begin
        CLK         = 1'b0;
        rst         = 1'b1;
        i_run       = 1'b0;
        i_step      = 1'b0;
        i_view_next = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        m_pc        = 0;
        m_a         = 0;
        m_b         = 0;
        m_mem7      = 0;
        m_z         = 1'b0;
        m_c         = 1'b0;
        model_decode();
        wait_cycles(10);
        rst = 1'b0;

        test_reset_state();
        test_single_step();
        test_hold();
        test_loop_memory();
        test_run_to_halt();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== cpu8.f ====
+incdir+hdl
hdl/cpu8_pkg.sv
hdl/program_rom.sv
hdl/instr_decoder.sv
hdl/cpu_alu.sv
hdl/cpu_datapath.sv
hdl/seg_display.sv
hdl/cpu8_top.sv
test/cpu8_tb.sv
